// File: Makefile
# Verilator flow for the data cache

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT  = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/dcache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
#(
    parameter int READ_DELAY = 4    // cycles from mem_ren to mem_rvalid
)
(
    input  wire         clk,
    input  wire         rst,
    output logic        mem_wrdy,
    input  wire         mem_wen,
    input  wire addr_t  mem_waddr,
    input  wire line_t  mem_wdata,
    output logic        mem_rrdy,
    input  wire         mem_ren,
    input  wire addr_t  mem_raddr,
    output logic        mem_rvalid,
    output line_t       mem_rdata,
    output int          rd_count,
    output int          wb_count,
    output addr_t       wb_addr,
    output line_t       wb_data
);

    line_t  lines [addr_t];    // lines written back so far
    addr_t  rd_addr_q;
    int     rd_wait;
    integer seed;

    // written lines win, all others follow the address rule
    function automatic line_t line_at(input addr_t line_addr);
        line_t l;
        if (lines.exists(line_addr))
        begin
            return lines[line_addr];
        end
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            l[i*WORD_BITS +: WORD_BITS] = (line_addr + addr_t'(4 * i)) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    initial
    begin
        seed       = 32'h9ba7_f678;
        mem_wrdy   = 1'b0;
        mem_rrdy   = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        rd_count   = 0;
        wb_count   = 0;
        wb_addr    = '0;
        wb_data    = '0;
        rd_wait    = 0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_wrdy   <= 1'b0;
            mem_rrdy   <= 1'b0;
            mem_rvalid <= 1'b0;
            rd_wait    <= 0;
            rd_count   <= 0;
            wb_count   <= 0;
        end
        else
        begin
            mem_wrdy   <= ($unsigned($random(seed)) % 3) != 0;    // busy about one cycle in three
            mem_rrdy   <= ($unsigned($random(seed)) % 3) != 0;
            mem_rvalid <= 1'b0;
            if (mem_wen)
            begin
                lines[mem_waddr] = mem_wdata;
                wb_count <= wb_count + 1;
                wb_addr  <= mem_waddr;
                wb_data  <= mem_wdata;
                $display("write-back of line %h at %0t ns", mem_waddr, $time);
            end
            if (mem_ren)
            begin
                rd_addr_q <= mem_raddr;
                rd_wait   <= READ_DELAY;
                rd_count  <= rd_count + 1;
            end
            else if (rd_wait == 1)
            begin
                mem_rvalid <= 1'b1;    // single-cycle answer
                mem_rdata  <= line_at(rd_addr_q);
                rd_wait    <= 0;
            end
            else if (rd_wait > 1)
            begin
                rd_wait <= rd_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int NUM_ROWS    = 16;
    localparam int ROW_CYCLES  = 200;
    localparam int CLK_PERIOD  = 10;
    localparam int WATCHDOG_NS = (NUM_ROWS * ROW_CYCLES + 20) * CLK_PERIOD;

    logic   clk;
    logic   rst;
    logic   ren;
    strb_t  wen;
    addr_t  addr;
    word_t  wdata;
    logic   ready;
    word_t  rdata;
    logic   rdata_valid;
    logic   mem_wrdy;
    logic   mem_wen;
    addr_t  mem_waddr;
    line_t  mem_wdata;
    logic   mem_rrdy;
    logic   mem_ren;
    addr_t  mem_raddr;
    logic   mem_rvalid;
    line_t  mem_rdata;
    int     rd_count;
    int     wb_count;
    addr_t  wb_addr;
    line_t  wb_data;

    // ********************
    // stimulus table, one request per row
    logic   row_load    [NUM_ROWS];
    addr_t  row_addr    [NUM_ROWS];
    word_t  row_wdata   [NUM_ROWS];
    strb_t  row_strb    [NUM_ROWS];
    word_t  row_exp     [NUM_ROWS];    // load result
    int     row_reads   [NUM_ROWS];    // memory reads caused by the row
    int     row_wbs     [NUM_ROWS];
    addr_t  row_wb_addr [NUM_ROWS];
    line_t  row_wb_line [NUM_ROWS];
    int     num_rows    = 0;
    int     loads_done  = 0;
    int     load_pulses = 0;

    dcache_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .ren         (ren),
        .wen         (wen),
        .addr        (addr),
        .wdata       (wdata),
        .ready       (ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem_wrdy    (mem_wrdy),
        .mem_wen     (mem_wen),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_rrdy    (mem_rrdy),
        .mem_ren     (mem_ren),
        .mem_raddr   (mem_raddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    dcache_mem_model mem0 (
        .clk        (clk),
        .rst        (rst),
        .mem_wrdy   (mem_wrdy),
        .mem_wen    (mem_wen),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_rrdy   (mem_rrdy),
        .mem_ren    (mem_ren),
        .mem_raddr  (mem_raddr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_count   (rd_count),
        .wb_count   (wb_count),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ********************
    // expected values from the memory rule
    function automatic word_t init_word(input addr_t a);
        return (a & ~addr_t'(3)) ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t init_line(input addr_t line_addr);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            l[i*WORD_BITS +: WORD_BITS] = init_word(line_addr + addr_t'(4 * i));
        end
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
            begin
                w[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return w;
    endfunction

    // ********************
    // failure reporting and compares
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic check_line(input string name, input line_t actual, input line_t expected);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %b, expected %b",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %0d, expected %0d",
                                    $time, name, actual, expected));
        end
    endtask

    // ********************
    // table rows
    task automatic add_row(input logic load, input addr_t a, input word_t d, input strb_t s,
                           input word_t exp, input int reads, input int wbs,
                           input addr_t wb_a, input line_t wb_l);
        row_load[num_rows]    = load;
        row_addr[num_rows]    = a;
        row_wdata[num_rows]   = d;
        row_strb[num_rows]    = s;
        row_exp[num_rows]     = exp;
        row_reads[num_rows]   = reads;
        row_wbs[num_rows]     = wbs;
        row_wb_addr[num_rows] = wb_a;
        row_wb_line[num_rows] = wb_l;
        num_rows++;
    endtask

    task automatic build_table();
        line_t wb_l;
        // set 2, fresh line then stores and loads in it
        add_row(1'b1, 32'h0000_1044, '0, '0, init_word(32'h0000_1044), 1, 0, '0, '0);
        add_row(1'b0, 32'h0000_1048, 32'hdead_beef, 4'hf, '0, 0, 0, '0, '0);
        add_row(1'b1, 32'h0000_1048, '0, '0, 32'hdead_beef, 0, 0, '0, '0);
        add_row(1'b1, 32'h0000_1050, '0, '0, init_word(32'h0000_1050), 0, 0, '0, '0);
        add_row(1'b0, 32'h0000_104c, 32'h1122_3344, 4'b0101, '0, 0, 0, '0, '0);
        add_row(1'b1, 32'h0000_104c, '0, '0,
                merge_bytes(init_word(32'h0000_104c), 32'h1122_3344, 4'b0101), 0, 0, '0, '0);
        // set 5, dirty line pushed out by a third tag
        wb_l = init_line(32'h0001_00a0);
        wb_l[1*WORD_BITS +: WORD_BITS] = 32'hcafe_f00d;
        add_row(1'b0, 32'h0001_00a4, 32'hcafe_f00d, 4'hf, '0, 1, 0, '0, '0);
        add_row(1'b1, 32'h0002_00a8, '0, '0, init_word(32'h0002_00a8), 1, 0, '0, '0);
        add_row(1'b1, 32'h0003_00ac, '0, '0, init_word(32'h0003_00ac), 1, 1,
                32'h0001_00a0, wb_l);
        add_row(1'b1, 32'h0001_00a4, '0, '0, 32'hcafe_f00d, 1, 0, '0, '0);
        // set 9, LRU keeps the line touched last
        add_row(1'b1, 32'h0004_0120, '0, '0, init_word(32'h0004_0120), 1, 0, '0, '0);
        add_row(1'b1, 32'h0005_0124, '0, '0, init_word(32'h0005_0124), 1, 0, '0, '0);
        add_row(1'b1, 32'h0004_0128, '0, '0, init_word(32'h0004_0128), 0, 0, '0, '0);
        add_row(1'b1, 32'h0006_012c, '0, '0, init_word(32'h0006_012c), 1, 0, '0, '0);
        add_row(1'b1, 32'h0004_0130, '0, '0, init_word(32'h0004_0130), 0, 0, '0, '0);
        add_row(1'b1, 32'h0005_0124, '0, '0, init_word(32'h0005_0124), 1, 0, '0, '0);
    endtask

    // ********************
    // row execution
    task automatic wait_ready(input int r);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ready)
        begin
            waited++;
            if (waited > ROW_CYCLES)
            begin
                stop_on_error($sformatf("row %0d: ready stayed low too long", r));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_load_data(input int r);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rdata_valid)
        begin
            waited++;
            if (waited > ROW_CYCLES)
            begin
                stop_on_error($sformatf("row %0d: load data never came back", r));
            end
            @(negedge clk);
        end
    endtask

    task automatic run_row(input int r);
        int reads_before;
        int wbs_before;
        @(posedge clk);
        check_count("rdata_valid pulses", load_pulses, loads_done);
        reads_before = rd_count;
        wbs_before   = wb_count;
        ren   <= row_load[r];
        wen   <= row_strb[r];
        addr  <= row_addr[r];
        wdata <= row_wdata[r];
        wait_ready(r);           // taken at the coming edge
        @(posedge clk);
        ren <= 1'b0;
        wen <= '0;
        if (row_load[r])
        begin
            wait_load_data(r);
            check_word($sformatf("row %0d rdata", r), rdata, row_exp[r]);
            loads_done++;
        end
        else
        begin
            wait_ready(r);       // store retired once ready is back
        end
        check_count($sformatf("row %0d memory reads", r), rd_count - reads_before, row_reads[r]);
        check_count($sformatf("row %0d write-backs", r), wb_count - wbs_before, row_wbs[r]);
        if (row_wbs[r] != 0)
        begin
            check_addr("mem_waddr", wb_addr, row_wb_addr[r]);
            check_line("mem_wdata", wb_data, row_wb_line[r]);
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst && rdata_valid)
        begin
            load_pulses++;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("watchdog expired after %0d ns, cache still busy", WATCHDOG_NS));
    end

    initial
    begin
        rst   = 1'b1;
        ren   = 1'b0;
        wen   = '0;
        addr  = '0;
        wdata = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // quiet bus until the first miss
        repeat (3)
        begin
            @(negedge clk);
            check_bit("mem_wen", mem_wen, 1'b0);
            check_bit("mem_ren", mem_ren, 1'b0);
            check_bit("rdata_valid", rdata_valid, 1'b0);
        end
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r);
        end
        repeat (3) @(posedge clk);
        check_count("rdata_valid pulses", load_pulses, loads_done);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/dcache_pkg.sv
src/dcache_way_ram.sv
src/dcache_req_stage.sv
src/dcache_lookup.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

// File: src/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup
    import dcache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         req_valid,
    input  wire         req_load,
    input  wire addr_t  req_addr,
    input  wire word_t  req_wdata,
    input  wire strb_t  req_strb,
    input  wire index_t rd_index,
    input  wire         refill_valid,
    input  wire line_t  refill_line,
    input  wire         wb_done,
    output logic        hit,
    output logic        hit_way,
    output word_t       load_word,
    output word_t       rdata,
    output logic        rdata_valid,
    output logic        victim_dirty,
    output tag_entry_t  victim_tag,
    output line_t       victim_line
);

    index_t                req_index;
    offset_t               req_offset;
    tag_entry_t            req_tag;
    tag_entry_t            tag_rd [NUM_WAYS];
    line_t                 line_rd [NUM_WAYS];
    logic [NUM_WAYS-1:0]   way_hit;
    logic [NUM_WAYS-1:0]   tag_we;
    line_mask_t            line_we [NUM_WAYS];
    line_mask_t            store_mask;
    line_t                 store_line;
    line_t                 wr_line;
    line_t                 hit_line;
    logic                  store_hit;
    logic                  victim_way;
    logic [NUM_WAYS-1:0]   dirty_q [NUM_SETS];
    logic [NUM_SETS-1:0]   lru_q;      // points at the next victim

    assign req_index  = req_addr[$clog2(LINE_BYTES) +: INDEX_BITS];
    assign req_offset = req_addr[$clog2(WORD_BITS / 8) +: OFFSET_BITS];
    assign req_tag    = '{valid: 1'b1, tag: req_addr[31 -: TAG_BITS]};

    // ********************
    // tag compare and word select
    assign hit       = |way_hit;
    assign hit_way   = way_hit[1];
    assign hit_line  = line_rd[hit_way];
    assign load_word = hit_line[req_offset * WORD_BITS +: WORD_BITS];

    assign victim_way   = lru_q[req_index];
    assign victim_dirty = dirty_q[req_index][victim_way];
    assign victim_tag   = tag_rd[victim_way];
    assign victim_line  = line_rd[victim_way];

    // ********************
    // store merge, word copied into every slot and masked by byte
    assign store_hit  = hit && !req_load;
    assign store_mask = line_mask_t'(req_strb) << (req_offset * (WORD_BITS / 8));
    assign store_line = {WORDS_PER_LINE{req_wdata}};
    assign wr_line    = refill_valid ? refill_line : store_line;

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        assign way_hit[w] = req_valid && (tag_rd[w] == req_tag);
        assign tag_we[w]  = refill_valid && (victim_way == 1'(w));   // refill writes whole line
        assign line_we[w] = tag_we[w] ? '1
                          : ((store_hit && (hit_way == 1'(w))) ? store_mask : '0);

        dcache_way_ram #(.payload_t(tag_entry_t)) tag_ram (
            .clk     (clk),
            .rst     (rst),
            .we      (tag_we[w]),
            .w_index (req_index),
            .w_data  (req_tag),
            .r_index (rd_index),
            .r_data  (tag_rd[w])
        );

        dcache_way_ram #(.payload_t(line_t)) line_ram (
            .clk     (clk),
            .rst     (rst),
            .we      (line_we[w]),
            .w_index (req_index),
            .w_data  (wr_line),
            .r_index (rd_index),
            .r_data  (line_rd[w])
        );
    end

    // ********************
    // dirty, LRU and load return
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                dirty_q[s] <= '0;
            end
            lru_q       <= '0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= hit && req_load;
            if (hit)
            begin
                lru_q[req_index] <= ~hit_way;     // other way ages out next
            end
            if (store_hit)
            begin
                dirty_q[req_index][hit_way] <= 1'b1;
            end
            if (wb_done)
            begin
                dirty_q[req_index][victim_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit && req_load)
        begin
            rdata <= load_word;
        end
    end

    // a line lives in one way only
    a_single_way : assert property (@(posedge clk) disable iff (rst)
        !(way_hit[0] && way_hit[1]))
        else $error("address hit in both ways");

endmodule

`default_nettype wire

// File: src/dcache_miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             req_valid,
    input  wire addr_t      req_addr,
    input  wire             hit,
    input  wire             victim_dirty,
    input  wire tag_entry_t victim_tag,
    input  wire line_t      victim_line,
    output logic            advance,
    output logic            ready,
    output logic            refill_valid,
    output line_t           refill_line,
    output logic            wb_done,
    input  wire             mem_wrdy,
    output logic            mem_wen,
    output addr_t           mem_waddr,
    output line_t           mem_wdata,
    input  wire             mem_rrdy,
    output logic            mem_ren,
    output addr_t           mem_raddr,
    input  wire             mem_rvalid,
    input  wire line_t      mem_rdata
);

    miss_state_t state;
    miss_state_t next_state;
    logic        pending;      // bus request out, waiting on it
    logic        wr_issue;
    logic        rd_issue;
    logic        rd_return;
    index_t      req_index;

    assign req_index = req_addr[$clog2(LINE_BYTES) +: INDEX_BITS];

    // pipe moves only when idle and the held request is done
    assign advance      = (state == IDLE) && (!req_valid || hit);
    assign ready        = advance;
    assign refill_valid = (state == REFILL);
    assign wb_done      = mem_wen;

    assign wr_issue  = (state == DIRTY_WRITE) && mem_wrdy && !pending;
    assign rd_issue  = (state == ASKMEM) && mem_rrdy && !pending;
    assign rd_return = (state == ASKMEM) && mem_rvalid && pending;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (req_valid && !hit)
                begin
                    next_state = victim_dirty ? DIRTY_WRITE : ASKMEM;
                end
            end
            DIRTY_WRITE:
            begin
                if (mem_wen)
                begin
                    next_state = ASKMEM;     // write pulse is on the bus
                end
            end
            ASKMEM:
            begin
                if (rd_return)
                begin
                    next_state = REFILL;
                end
            end
            REFILL:      next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= IDLE;
            pending <= 1'b0;
            mem_wen <= 1'b0;
            mem_ren <= 1'b0;
        end
        else
        begin
            state   <= next_state;
            mem_wen <= wr_issue;     // one-cycle pulses
            mem_ren <= rd_issue;
            if (mem_wen || rd_return)
            begin
                pending <= 1'b0;
            end
            else if (wr_issue || rd_issue)
            begin
                pending <= 1'b1;
            end
        end
    end

    // bus payloads, latched with their pulse
    always_ff @(posedge clk)
    begin
        if (wr_issue)
        begin
            mem_waddr <= {victim_tag.tag, req_index, {$clog2(LINE_BYTES){1'b0}}};
            mem_wdata <= victim_line;
        end
        if (rd_issue)
        begin
            mem_raddr <= req_addr & ~addr_t'(LINE_BYTES - 1);   // line aligned
        end
        if (rd_return)
        begin
            refill_line <= mem_rdata;
        end
    end

    a_one_bus_op : assert property (@(posedge clk) disable iff (rst)
        !(mem_wen && mem_ren))
        else $error("write-back and refill read issued together");

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ********************
    // cache geometry
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 128;
    localparam int INDEX_BITS     = 7;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS    = 3;    // word offset inside a line
    localparam int TAG_BITS       = 20;
    localparam int WORD_BITS      = 32;
    localparam int LINE_BITS      = 256;
    localparam int LINE_BYTES     = 32;

    // ********************
    // address fields and payloads
    typedef logic [31:0]              addr_t;
    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [WORD_BITS/8-1:0]   strb_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;

    typedef struct packed {
        logic                valid;   // line holds data
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef logic [LINE_BITS-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0]    line_mask_t;    // one bit per byte

    // ********************
    // miss handling
    typedef enum logic [1:0] {
        IDLE,
        DIRTY_WRITE,    // victim going out
        ASKMEM,         // refill read issued
        REFILL          // line written into the arrays
    } miss_state_t;

endpackage

`default_nettype wire

// File: src/dcache_req_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_req_stage
    import dcache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         ren,
    input  wire strb_t  wen,
    input  wire addr_t  addr,
    input  wire word_t  wdata,
    input  wire         advance,
    output logic        req_valid,
    output logic        req_load,
    output addr_t       req_addr,
    output word_t       req_wdata,
    output strb_t       req_strb,
    output index_t      rd_index
);

    // request flags, an idle cycle clears them
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_valid <= 1'b0;
            req_load  <= 1'b0;
        end
        else if (advance)
        begin
            req_valid <= ren || (wen != '0);
            req_load  <= ren;
        end
    end

    // held payload of the request
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_strb  <= wen;
        end
    end

    // arrays read the incoming set only when the pipe moves
    assign rd_index = advance ? addr[$clog2(LINE_BYTES) +: INDEX_BITS]
                              : req_addr[$clog2(LINE_BYTES) +: INDEX_BITS];

    // one request kind per cycle from the CPU
    a_one_kind : assert property (@(posedge clk) disable iff (rst)
        !(ren && (wen != '0)))
        else $error("load and store requested in the same cycle");

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         ren,
    input  wire strb_t  wen,
    input  wire addr_t  addr,
    input  wire word_t  wdata,
    output logic        ready,
    output word_t       rdata,
    output logic        rdata_valid,
    input  wire         mem_wrdy,
    output logic        mem_wen,
    output addr_t       mem_waddr,
    output line_t       mem_wdata,
    input  wire         mem_rrdy,
    output logic        mem_ren,
    output addr_t       mem_raddr,
    input  wire         mem_rvalid,
    input  wire line_t  mem_rdata
);

    logic       advance;
    logic       req_valid;
    logic       req_load;
    addr_t      req_addr;
    word_t      req_wdata;
    strb_t      req_strb;
    index_t     rd_index;
    logic       hit;
    logic       victim_dirty;
    tag_entry_t victim_tag;
    line_t      victim_line;
    logic       refill_valid;
    line_t      refill_line;
    logic       wb_done;

    dcache_req_stage req_stage0 (
        .clk       (clk),
        .rst       (rst),
        .ren       (ren),
        .wen       (wen),
        .addr      (addr),
        .wdata     (wdata),
        .advance   (advance),
        .req_valid (req_valid),
        .req_load  (req_load),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_strb  (req_strb),
        .rd_index  (rd_index)
    );

    dcache_lookup lookup0 (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_load     (req_load),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_strb     (req_strb),
        .rd_index     (rd_index),
        .refill_valid (refill_valid),
        .refill_line  (refill_line),
        .wb_done      (wb_done),
        .hit          (hit),
        .hit_way      (),            // used inside the lookup only
        .load_word    (),
        .rdata        (rdata),
        .rdata_valid  (rdata_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    dcache_miss_ctrl miss_ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .advance      (advance),
        .ready        (ready),
        .refill_valid (refill_valid),
        .refill_line  (refill_line),
        .wb_done      (wb_done),
        .mem_wrdy     (mem_wrdy),
        .mem_wen      (mem_wen),
        .mem_waddr    (mem_waddr),
        .mem_wdata    (mem_wdata),
        .mem_rrdy     (mem_rrdy),
        .mem_ren      (mem_ren),
        .mem_raddr    (mem_raddr),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// File: src/dcache_way_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_way_ram
    import dcache_pkg::*;
#(
    parameter type payload_t = line_t,
    localparam int DATA_BITS = $bits(payload_t),
    localparam int LANES     = (DATA_BITS % 8 == 0) ? DATA_BITS / 8 : 1,
    localparam int LANE_BITS = DATA_BITS / LANES
)
(
    input  wire             clk,
    input  wire             rst,
    input  wire [LANES-1:0] we,
    input  wire index_t     w_index,
    input  wire payload_t   w_data,
    input  wire index_t     r_index,
    output payload_t        r_data
);

    logic [DATA_BITS-1:0] mem [NUM_SETS];
    logic [DATA_BITS-1:0] w_bits;
    logic [DATA_BITS-1:0] mem_q;
    logic [DATA_BITS-1:0] fwd_bits;
    logic [DATA_BITS-1:0] rd_bits;
    logic [LANES-1:0]     fwd_we;
    index_t               fwd_index;
    index_t               r_index_q;

    assign w_bits = w_data;

    // all-zero content at power-up, so no entry starts valid
    initial
    begin
        for (int i = 0; i < NUM_SETS; i++)
        begin
            mem[i] = '0;
        end
    end

    always @(posedge clk)
    begin
        for (int l = 0; l < LANES; l++)
        begin
            if (we[l])
            begin
                mem[w_index][l*LANE_BITS +: LANE_BITS] <= w_bits[l*LANE_BITS +: LANE_BITS];
            end
        end
        mem_q <= mem[r_index];     // read sees the old content
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fwd_we <= '0;
        end
        else
        begin
            fwd_we <= we;
        end
    end

    always_ff @(posedge clk)
    begin
        fwd_bits  <= w_bits;
        fwd_index <= w_index;
        r_index_q <= r_index;
    end

    // last cycle's write wins over the stale read, lane by lane
    always_comb
    begin
        rd_bits = mem_q;
        if (fwd_index == r_index_q)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (fwd_we[l])
                begin
                    rd_bits[l*LANE_BITS +: LANE_BITS] = fwd_bits[l*LANE_BITS +: LANE_BITS];
                end
            end
        end
    end

    assign r_data = payload_t'(rd_bits);

endmodule

`default_nettype wire
